//--- Bender.yml
package:
  name: resource_alloc

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/disp_pkg.sv
      - design/backend_pkg.sv
      - design/credit_counter.sv
      - design/brtag_freelist.sv
      - design/resource_alloc.sv

  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_resource_alloc.sv

//--- bench/tb_resource_alloc.sv
// Testbench for the dispatch resource allocator: xorshift stimulus,
// reference model of credits and branch tags, checking assertions
`include "alloc_settings.svh"

module tb_resource_alloc;
  timeunit 1ns;
  timeprecision 1ps;

  // Structure index: ROB, ALU queues, then LSU, LDQ, STQ, BRU
  localparam int NS   = `ALLOC_ALU_NUM + 5;
  localparam int LSU  = `ALLOC_ALU_NUM + 1;
  localparam int LDQ  = `ALLOC_ALU_NUM + 2;
  localparam int STQ  = `ALLOC_ALU_NUM + 3;
  localparam int BRU  = `ALLOC_ALU_NUM + 4;
  localparam int NTAG = `ALLOC_BRU_ENTRIES;

  localparam int FLUSH_CYCLES = 12;
  localparam int STALL_CYCLES = 40;
  localparam int RAND_CYCLES  = 600;
  // Reset, ROB fill and drain, flush, stall, random and tail
  localparam int TEST_CYCLES  = 10 + 3 * `ALLOC_ROB_ENTRIES + FLUSH_CYCLES +
                                STALL_CYCLES + RAND_CYCLES + 4;
  localparam int MAX_CYCLES   = 2 * TEST_CYCLES;

  logic                    i_clk = 1'b0;
  logic                    i_arst_n;
  logic                    i_disp_valid;
  logic                    i_disp_ready;
  disp_pkg::res_cnt_t      i_disp_cnt;
  logic                    i_commit_flush;
  backend_pkg::br_upd_t    i_br_upd;
  backend_pkg::cre_ret_t   ret_q [NS];
  backend_pkg::cre_ret_t   i_alu_ret [`ALLOC_ALU_NUM];
  backend_pkg::brtag_ret_t i_brtag_ret;
  logic                    o_resource_ok;
  disp_pkg::brtag_t        o_brtag [`ALLOC_DISP_SIZE];

  // Reference model state
  int                      m_used [NS];
  logic [NTAG-1:0]         m_free;
  int                      m_free_cnt;
  logic                    exp_ok;
  int                      exp_tag0;
  int                      exp_tag1;
  logic                    m_flush;
  logic                    m_fire;
  logic                    hold_chk;
  logic                    prev_ok;
  int                      prev_tag0;

  logic [31:0]             rng = 32'hf2c0_37f2;
  int                      err_count = 0;
  int                      cycle_count = 0;

  always #20 i_clk = ~i_clk;

  for (genvar a = 0; a < `ALLOC_ALU_NUM; a++) begin : g_alu_ret
    assign i_alu_ret[a] = ret_q[1 + a];
  end

  resource_alloc dut (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_disp_valid   (i_disp_valid),
    .i_disp_ready   (i_disp_ready),
    .i_disp_cnt     (i_disp_cnt),
    .i_commit_flush (i_commit_flush),
    .i_br_upd       (i_br_upd),
    .i_rob_ret      (ret_q[0]),
    .i_alu_ret      (i_alu_ret),
    .i_lsu_ret      (ret_q[LSU]),
    .i_ldq_ret      (ret_q[LDQ]),
    .i_stq_ret      (ret_q[STQ]),
    .i_bru_ret      (ret_q[BRU]),
    .i_brtag_ret    (i_brtag_ret),
    .o_resource_ok  (o_resource_ok),
    .o_brtag        (o_brtag)
  );

  // ----------------------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int rand_below(input int n);
    rng = xorshift(rng);
    return int'(rng % n);
  endfunction

  // Index of the n-th lowest free tag, -1 if none
  function automatic int nth_free(input logic [NTAG-1:0] map, input int n);
    int seen;
    seen = 0;
    for (int t = 0; t < NTAG; t++) begin
      if (map[t]) begin
        if (seen == n) return t;
        seen++;
      end
    end
    return -1;
  endfunction

  function automatic int capacity(input int s);
    case (s)
      0:       return `ALLOC_ROB_ENTRIES;
      LSU:     return `ALLOC_LSU_ENTRIES;
      LDQ:     return `ALLOC_LDQ_ENTRIES;
      STQ:     return `ALLOC_STQ_ENTRIES;
      BRU:     return `ALLOC_BRU_ENTRIES;
      default: return `ALLOC_ALU_ENTRIES / `ALLOC_ALU_NUM;
    endcase
  endfunction

  // Entries structure s takes in this cycle
  function automatic int take_cnt(input int s);
    int n;
    case (s)
      0:       n = 1;
      LSU:     n = i_disp_cnt.lsu_cnt;
      LDQ:     n = i_disp_cnt.ldq_cnt;
      STQ:     n = i_disp_cnt.stq_cnt;
      BRU:     n = i_disp_cnt.bru_cnt;
      default: n = i_disp_cnt.alu_cnt[s-1];
    endcase
    return m_fire ? n : 0;
  endfunction

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------

  assign m_flush = i_commit_flush |
                   (i_br_upd.update & ~i_br_upd.dead & i_br_upd.mispredict);
  assign m_fire  = i_disp_valid & i_disp_ready & ~m_flush;

  always @(posedge i_clk or negedge i_arst_n) begin : ref_model
    logic [NTAG-1:0] pop_mask;
    logic [NTAG-1:0] nxt_free;
    int              nxt_used;
    logic            ok;
    logic            quiet;
    pop_mask = '0;
    quiet    = !i_brtag_ret.valid;
    ok       = 1'b1;
    for (int k = 0; k < `ALLOC_DISP_SIZE; k++) begin
      if (m_fire && i_disp_cnt.br_valid[k] && nth_free(m_free, k) >= 0) begin
        pop_mask[nth_free(m_free, k)] = 1'b1;
      end
    end
    nxt_free = m_free & ~pop_mask;
    if (i_brtag_ret.valid) nxt_free[i_brtag_ret.tag] = 1'b1;
    if (!i_arst_n) nxt_free = '1;
    for (int s = 0; s < NS; s++) begin
      nxt_used = m_used[s] + take_cnt(s) - (ret_q[s].valid ? int'(ret_q[s].cnt) : 0);
      if (!i_arst_n) nxt_used = 0;
      if (ret_q[s].valid) quiet = 1'b0;
      // Worst case is one ROB entry, or a full group elsewhere
      if (capacity(s) - nxt_used < (s == 0 ? 1 : `ALLOC_DISP_SIZE)) ok = 1'b0;
      m_used[s] <= nxt_used;
    end
    m_free     <= nxt_free;
    m_free_cnt <= $countones(nxt_free);
    exp_ok     <= ok;
    exp_tag0   <= nth_free(nxt_free, 0);
    exp_tag1   <= nth_free(nxt_free, 1);
    // Flushed or stalled cycle without returns leaves state alone
    hold_chk   <= i_arst_n && quiet &&
                  ((i_disp_valid && i_disp_ready && m_flush) || !i_disp_ready);
    prev_ok    <= o_resource_ok;
    prev_tag0  <= o_brtag[0];
  end

  // ----------------------------------------------------------------------
  // Checks
  // ----------------------------------------------------------------------

  a_reset_state : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    $rose(i_arst_n) |-> (o_resource_ok && o_brtag[0] == 0 && o_brtag[1] == 1))
    else begin
      err_count++;
      $display(
        "ERROR at %0t: o_resource_ok expected 1 actual %0b, o_brtag expected 0 1 actual %0d %0d",
        $time, $sampled(o_resource_ok), $sampled(o_brtag[0]), $sampled(o_brtag[1]));
    end

  a_ok_model : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_resource_ok == exp_ok)
    else begin
      err_count++;
      $display("ERROR at %0t: o_resource_ok expected %0b actual %0b",
               $time, $sampled(exp_ok), $sampled(o_resource_ok));
    end

  a_tag0_model : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (m_free_cnt >= 1) |-> (o_brtag[0] == exp_tag0))
    else begin
      err_count++;
      $display("ERROR at %0t: o_brtag[0] expected %0d actual %0d",
               $time, $sampled(exp_tag0), $sampled(o_brtag[0]));
    end

  a_tag1_model : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    (m_free_cnt >= 2) |-> (o_brtag[1] == exp_tag1 && o_brtag[1] != o_brtag[0]))
    else begin
      err_count++;
      $display("ERROR at %0t: o_brtag[1] expected %0d actual %0d",
               $time, $sampled(exp_tag1), $sampled(o_brtag[1]));
    end

  a_hold_ok : assert property (@(posedge i_clk) disable iff (!i_arst_n)
    hold_chk |-> (o_resource_ok == prev_ok && o_brtag[0] == prev_tag0))
    else begin
      err_count++;
      $display(
        "ERROR at %0t: o_resource_ok expected %0b actual %0b, o_brtag[0] expected %0d actual %0d",
        $time, $sampled(prev_ok), $sampled(o_resource_ok),
        $sampled(prev_tag0), $sampled(o_brtag[0]));
    end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Result: FAILED");
      $finish;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  task automatic idle_inputs;
    i_disp_valid   = 1'b0;
    i_disp_ready   = 1'b0;
    i_disp_cnt     = '0;
    i_commit_flush = 1'b0;
    i_br_upd       = '0;
    i_brtag_ret    = '0;
    for (int s = 0; s < NS; s++) begin
      ret_q[s] = '0;
    end
  endtask

  // Random counts, branch slots only while tags are free
  task automatic random_request;
    int nb;
    for (int a = 0; a < `ALLOC_ALU_NUM; a++) begin
      i_disp_cnt.alu_cnt[a] = disp_pkg::cnt_t'(rand_below(3));
    end
    i_disp_cnt.lsu_cnt = disp_pkg::cnt_t'(rand_below(3));
    i_disp_cnt.ldq_cnt = disp_pkg::cnt_t'(rand_below(3));
    i_disp_cnt.stq_cnt = disp_pkg::cnt_t'(rand_below(3));
    nb = rand_below(3);
    i_disp_cnt.bru_cnt = disp_pkg::cnt_t'(nb);
    if (nb == 2 && m_free_cnt >= 2) i_disp_cnt.br_valid = 2'b11;
    else if (nb >= 1 && m_free_cnt >= 2) i_disp_cnt.br_valid = rand_below(2) ? 2'b10 : 2'b01;
    else if (nb >= 1 && m_free_cnt == 1) i_disp_cnt.br_valid = 2'b01;
  endtask

  // Backend hands back only what it holds
  task automatic random_returns;
    int tag;
    for (int s = 0; s < NS; s++) begin
      if (m_used[s] > 0 && rand_below(3) == 0) begin
        ret_q[s].valid = 1'b1;
        ret_q[s].cnt   = disp_pkg::cnt_t'(1 + rand_below(m_used[s] >= 2 ? 2 : 1));
      end
    end
    if (m_free != '1 && rand_below(3) == 0) begin
      tag = rand_below(NTAG);
      while (m_free[tag]) tag = (tag + 1) % NTAG;
      i_brtag_ret.valid = 1'b1;
      i_brtag_ret.tag   = disp_pkg::brtag_t'(tag);
    end
  endtask

  task automatic rob_fill_phase;
    int fires;
    fires = 0;
    while (o_resource_ok) begin
      idle_inputs();
      i_disp_valid = 1'b1;
      i_disp_ready = 1'b1;
      fires++;
      @(negedge i_clk);
    end
    idle_inputs();
    a_rob_fires : assert (fires == `ALLOC_ROB_ENTRIES) else begin
      err_count++;
      $display("ERROR at %0t: dispatches to fill ROB expected %0d actual %0d",
               $time, `ALLOC_ROB_ENTRIES, fires);
    end
    repeat (2) @(negedge i_clk);
    ret_q[0].valid = 1'b1;
    ret_q[0].cnt   = disp_pkg::cnt_t'(1);
    @(negedge i_clk);
    while (m_used[0] > 0) begin
      idle_inputs();
      ret_q[0].valid = 1'b1;
      ret_q[0].cnt   = disp_pkg::cnt_t'(m_used[0] >= 2 ? 2 : 1);
      @(negedge i_clk);
    end
    idle_inputs();
  endtask

  // Commit flush, live mispredict, then a dead one that still fires
  task automatic flush_phase;
    for (int i = 0; i < FLUSH_CYCLES; i++) begin
      idle_inputs();
      random_request();
      i_disp_ready = 1'b1;
      i_disp_valid = 1'b1;
      case (i % 3)
        0:       i_commit_flush = 1'b1;
        1:       i_br_upd = '{update: 1'b1, dead: 1'b0, mispredict: 1'b1};
        default: begin
          i_br_upd     = '{update: 1'b1, dead: 1'b1, mispredict: 1'b1};
          i_disp_valid = o_resource_ok;
        end
      endcase
      @(negedge i_clk);
    end
  endtask

  task automatic stall_phase;
    for (int i = 0; i < STALL_CYCLES; i++) begin
      idle_inputs();
      random_request();
      i_disp_valid = 1'b1;
      if (i % 2) random_returns();
      @(negedge i_clk);
    end
  endtask

  task automatic random_phase;
    for (int i = 0; i < RAND_CYCLES; i++) begin
      idle_inputs();
      random_request();
      i_disp_valid   = o_resource_ok && rand_below(4) != 0;
      i_disp_ready   = rand_below(5) != 0;
      i_commit_flush = rand_below(16) == 0;
      if (rand_below(8) == 0) begin
        i_br_upd.update     = 1'b1;
        i_br_upd.dead       = rand_below(2);
        i_br_upd.mispredict = rand_below(2);
      end
      random_returns();
      @(negedge i_clk);
    end
  endtask

  initial begin
    i_arst_n = 1'b0;
    idle_inputs();
    repeat (10) @(negedge i_clk);
    i_arst_n = 1'b1;
    rob_fill_phase();
    flush_phase();
    stall_phase();
    random_phase();
    idle_inputs();
    repeat (3) @(negedge i_clk);
    $display("Summary: %0d errors in %0d cycles", err_count, cycle_count);
    if (err_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
design/disp_pkg.sv
design/backend_pkg.sv
design/credit_counter.sv
design/brtag_freelist.sv
design/resource_alloc.sv
bench/tb_resource_alloc.sv

//--- design/backend_pkg.sv
// Backend-side types: credit returns, branch resolution updates
// and returned branch tags
`include "alloc_settings.svh"

package backend_pkg;

  // Credits handed back by one structure, single-cycle pulse
  typedef struct packed {
    logic            valid;
    disp_pkg::cnt_t  cnt;
  } cre_ret_t;

  // Branch resolution from the branch unit
  typedef struct packed {
    logic update;
    // Branch was already squashed, ignore it
    logic dead;
    logic mispredict;
  } br_upd_t;

  // Branch tag freed by the branch unit
  typedef struct packed {
    logic              valid;
    disp_pkg::brtag_t  tag;
  } brtag_ret_t;

endpackage

//--- design/brtag_freelist.sv
// Bitmap freelist of branch tags, hands out the lowest free tags
// to several pop ports and takes back one tag per cycle
`include "alloc_settings.svh"

module brtag_freelist #(
  parameter int SIZE  = 4,
  parameter int PORTS = 2
) (
  input  logic                    i_clk,
  input  logic                    i_arst_n,

  input  logic [PORTS-1:0]        i_pop,
  input  backend_pkg::brtag_ret_t i_push,

  output disp_pkg::brtag_t        o_pop_id [PORTS],
  output logic                    o_is_empty
);

  // Bit set means tag is free
  logic [SIZE-1:0] r_free;
  logic [SIZE-1:0] w_remain;
  logic [SIZE-1:0] w_lowest;
  logic [SIZE-1:0] w_pop_mask;
  logic [SIZE-1:0] w_push_mask;

  // ----------------------------------------------------------------------
  // Priority search
  // ----------------------------------------------------------------------

  // Port p gets the p-th lowest free tag, whether or not it pops
  always_comb begin
    w_remain   = r_free;
    w_lowest   = '0;
    w_pop_mask = '0;
    for (int p = 0; p < PORTS; p++) begin
      // Isolate lowest set bit
      w_lowest    = w_remain & (~w_remain + 1'b1);
      o_pop_id[p] = '0;
      for (int i = 0; i < SIZE; i++) begin
        if (w_lowest[i]) begin
          o_pop_id[p] = disp_pkg::brtag_t'(i);
        end
      end
      if (i_pop[p]) begin
        w_pop_mask = w_pop_mask | w_lowest;
      end
      w_remain = w_remain & ~w_lowest;
    end
  end

  assign w_push_mask = i_push.valid ? (SIZE'(1) << i_push.tag) : '0;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_free <= '1;
    end else begin
      r_free <= (r_free & ~w_pop_mask) | w_push_mask;
    end
  end

  assign o_is_empty = ~|r_free;

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  a_pop_avail : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    $countones(i_pop) <= $countones(r_free)
  ) else $error("brtag_freelist: %0d pops, %0d free", $countones(i_pop), $countones(r_free));

  // Branch unit frees a tag twice
  a_push_busy : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_push.valid |-> !r_free[i_push.tag]
  ) else $error("brtag_freelist: tag %0d pushed while free", i_push.tag);

  // Tag handed to dispatch and freed by the branch unit at once
  a_push_not_popped : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_push.valid |-> !w_pop_mask[i_push.tag]
  ) else $error("brtag_freelist: tag %0d pushed and popped together", i_push.tag);

endmodule

//--- design/credit_counter.sv
// Credit counter for one backend structure with a no-room flag
`include "alloc_settings.svh"

module credit_counter #(
  parameter int MAX_CREDITS = 8,
  parameter int MAX_GET     = 2
) (
  input  logic                  i_clk,
  input  logic                  i_arst_n,

  input  logic                  i_get,
  input  disp_pkg::cnt_t        i_get_val,
  input  backend_pkg::cre_ret_t i_ret,

  output logic                  o_no_credits
);

  localparam int CW = $clog2(MAX_CREDITS + 1);

  logic [CW-1:0] r_used;
  logic [CW-1:0] w_get_val;
  logic [CW-1:0] w_ret_val;
  logic [CW-1:0] w_free;

  // Zero when not taking or not returning
  assign w_get_val = i_get ? CW'(i_get_val) : '0;
  assign w_ret_val = i_ret.valid ? CW'(i_ret.cnt) : '0;

  // Take and return may land in the same cycle
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      r_used <= '0;
    end else begin
      r_used <= r_used + w_get_val - w_ret_val;
    end
  end

  // No room for a worst-case group
  assign w_free       = CW'(MAX_CREDITS) - r_used;
  assign o_no_credits = w_free < CW'(MAX_GET);

  // ----------------------------------------------------------------------
  // Assertions
  // ----------------------------------------------------------------------

  // Front end dispatched past a low o_resource_ok
  a_no_overflow : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    r_used <= CW'(MAX_CREDITS)
  ) else $error("credit_counter: used %0d exceeds %0d", r_used, MAX_CREDITS);

  // Backend hands back credits it never got
  a_no_underflow : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_ret.valid |-> (w_ret_val <= r_used)
  ) else $error("credit_counter: return %0d with only %0d in use", w_ret_val, r_used);

endmodule

//--- design/disp_pkg.sv
// Dispatch-side types: per-structure entry counts, branch tags
// and the resource request of one dispatch group
`include "alloc_settings.svh"

package disp_pkg;

  // ----------------------------------------------------------------------
  // Scalar types
  // ----------------------------------------------------------------------

  // Entries one group needs in one structure, 0 .. DISP_SIZE
  typedef logic [$clog2(`ALLOC_DISP_SIZE + 1)-1:0] cnt_t;

  // One tag per branch unit entry
  typedef logic [$clog2(`ALLOC_BRU_ENTRIES)-1:0] brtag_t;

  // ----------------------------------------------------------------------
  // Group request
  // ----------------------------------------------------------------------

  // What the front end asks for with one dispatch group
  typedef struct packed {
    // Per ALU issue queue
    cnt_t [`ALLOC_ALU_NUM-1:0]   alu_cnt;
    cnt_t                        lsu_cnt;
    cnt_t                        ldq_cnt;
    cnt_t                        stq_cnt;
    cnt_t                        bru_cnt;
    // Slot k holds a branch and needs a tag
    logic [`ALLOC_DISP_SIZE-1:0] br_valid;
  } res_cnt_t;

endpackage

//--- design/resource_alloc.sv
// Dispatch-stage resource allocator: flush and fire decode, credit
// counters for every backend structure and the branch tag freelist
`include "alloc_settings.svh"

module resource_alloc (
  input  logic                    i_clk,
  input  logic                    i_arst_n,

  // Front end
  input  logic                    i_disp_valid,
  input  logic                    i_disp_ready,
  input  disp_pkg::res_cnt_t      i_disp_cnt,

  // Flush sources
  input  logic                    i_commit_flush,
  input  backend_pkg::br_upd_t    i_br_upd,

  // Credit returns
  input  backend_pkg::cre_ret_t   i_rob_ret,
  input  backend_pkg::cre_ret_t   i_alu_ret [`ALLOC_ALU_NUM],
  input  backend_pkg::cre_ret_t   i_lsu_ret,
  input  backend_pkg::cre_ret_t   i_ldq_ret,
  input  backend_pkg::cre_ret_t   i_stq_ret,
  input  backend_pkg::cre_ret_t   i_bru_ret,

  // Tag return from the branch unit
  input  backend_pkg::brtag_ret_t i_brtag_ret,

  output logic                    o_resource_ok,
  output disp_pkg::brtag_t        o_brtag [`ALLOC_DISP_SIZE]
);

  localparam int ALU_Q_ENTRIES = `ALLOC_ALU_ENTRIES / `ALLOC_ALU_NUM;

  logic                      w_br_flush;
  logic                      w_flush;
  logic                      w_fire;

  logic                      w_rob_no_cre;
  logic [`ALLOC_ALU_NUM-1:0] w_alu_no_cre;
  logic                      w_lsu_no_cre;
  logic                      w_ldq_no_cre;
  logic                      w_stq_no_cre;
  logic                      w_bru_no_cre;

  // ----------------------------------------------------------------------
  // Fire and flush
  // ----------------------------------------------------------------------

  // Dead branches no longer redirect anything
  assign w_br_flush = i_br_upd.update & ~i_br_upd.dead & i_br_upd.mispredict;
  assign w_flush    = i_commit_flush | w_br_flush;
  assign w_fire     = i_disp_valid & i_disp_ready & ~w_flush;

  assign o_resource_ok = ~(w_rob_no_cre | (|w_alu_no_cre) | w_lsu_no_cre |
                           w_ldq_no_cre | w_stq_no_cre | w_bru_no_cre);

  // ----------------------------------------------------------------------
  // Credit counters
  // ----------------------------------------------------------------------

  // One ROB credit per group
  credit_counter #(.MAX_CREDITS(`ALLOC_ROB_ENTRIES), .MAX_GET(1)) u_rob_cre (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_get        (w_fire),
    .i_get_val    (disp_pkg::cnt_t'(1)),
    .i_ret        (i_rob_ret),
    .o_no_credits (w_rob_no_cre)
  );

  for (genvar a = 0; a < `ALLOC_ALU_NUM; a++) begin : g_alu_cre
    credit_counter #(.MAX_CREDITS(ALU_Q_ENTRIES), .MAX_GET(`ALLOC_DISP_SIZE)) u_alu_cre (
      .i_clk        (i_clk),
      .i_arst_n     (i_arst_n),
      .i_get        (w_fire & (|i_disp_cnt.alu_cnt[a])),
      .i_get_val    (i_disp_cnt.alu_cnt[a]),
      .i_ret        (i_alu_ret[a]),
      .o_no_credits (w_alu_no_cre[a])
    );
  end

  credit_counter #(.MAX_CREDITS(`ALLOC_LSU_ENTRIES), .MAX_GET(`ALLOC_DISP_SIZE)) u_lsu_cre (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_get        (w_fire & (|i_disp_cnt.lsu_cnt)),
    .i_get_val    (i_disp_cnt.lsu_cnt),
    .i_ret        (i_lsu_ret),
    .o_no_credits (w_lsu_no_cre)
  );

  credit_counter #(.MAX_CREDITS(`ALLOC_LDQ_ENTRIES), .MAX_GET(`ALLOC_DISP_SIZE)) u_ldq_cre (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_get        (w_fire & (|i_disp_cnt.ldq_cnt)),
    .i_get_val    (i_disp_cnt.ldq_cnt),
    .i_ret        (i_ldq_ret),
    .o_no_credits (w_ldq_no_cre)
  );

  credit_counter #(.MAX_CREDITS(`ALLOC_STQ_ENTRIES), .MAX_GET(`ALLOC_DISP_SIZE)) u_stq_cre (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_get        (w_fire & (|i_disp_cnt.stq_cnt)),
    .i_get_val    (i_disp_cnt.stq_cnt),
    .i_ret        (i_stq_ret),
    .o_no_credits (w_stq_no_cre)
  );

  credit_counter #(.MAX_CREDITS(`ALLOC_BRU_ENTRIES), .MAX_GET(`ALLOC_DISP_SIZE)) u_bru_cre (
    .i_clk        (i_clk),
    .i_arst_n     (i_arst_n),
    .i_get        (w_fire & (|i_disp_cnt.bru_cnt)),
    .i_get_val    (i_disp_cnt.bru_cnt),
    .i_ret        (i_bru_ret),
    .o_no_credits (w_bru_no_cre)
  );

  // ----------------------------------------------------------------------
  // Branch tags
  // ----------------------------------------------------------------------

  // Tags come out combinationally and are valid in the fire cycle
  brtag_freelist #(.SIZE(`ALLOC_BRU_ENTRIES), .PORTS(`ALLOC_DISP_SIZE)) u_brtag_fl (
    .i_clk      (i_clk),
    .i_arst_n   (i_arst_n),
    .i_pop      ({`ALLOC_DISP_SIZE{w_fire}} & i_disp_cnt.br_valid),
    .i_push     (i_brtag_ret),
    .o_pop_id   (o_brtag),
    .o_is_empty ()
  );

  // Tag pops must stay covered by BRU credits, else tags run out first
  a_br_within_bru : assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    w_fire |-> ($countones(i_disp_cnt.br_valid) <= i_disp_cnt.bru_cnt)
  ) else $error("resource_alloc: %0d branch slots, BRU count %0d",
                $countones(i_disp_cnt.br_valid), i_disp_cnt.bru_cnt);

endmodule

//--- include/alloc_settings.svh
// Dispatch group width, backend unit counts and queue sizes
// for the dispatch-stage resource allocator
`ifndef ALLOC_SETTINGS_SVH
`define ALLOC_SETTINGS_SVH

// ----------------------------------------------------------------------
// Dispatch group
// ----------------------------------------------------------------------
`define ALLOC_DISP_SIZE     2
`define ALLOC_ALU_NUM       2

// ----------------------------------------------------------------------
// Backend structure sizes
// ----------------------------------------------------------------------
// ROB takes one credit per dispatch group
`define ALLOC_ROB_ENTRIES   16
// Split evenly over the ALU issue queues
`define ALLOC_ALU_ENTRIES   8
`define ALLOC_LSU_ENTRIES   4
`define ALLOC_LDQ_ENTRIES   8
`define ALLOC_STQ_ENTRIES   8
// Branch unit entries, also the number of branch tags
`define ALLOC_BRU_ENTRIES   4

`endif
